/* src/periphPkg.sv */
//////////////////////////////////////////////////
// Peripheral package: bus and data vector types,
// register group codes, status and IRQ enable bits
//////////////////////////////////////////////////

package periphPkg;

	// Bus and data vectors
	typedef logic [31:0] word_t;	// One bus word
	typedef logic [7:0]  byte_t;	// UART byte or PWM duty
	typedef logic [5:0]  regAddr_t;	// Word address bits 7..2
	typedef logic [3:0]  strb_t;	// Byte lane write strobes
	typedef logic [29:0] vecAddr_t;	// Word aligned IRQ vector
	typedef logic [4:0]  irqEn_t;	// IRQ enable mask

	// Register groups, address bits 7..5
	localparam logic [2:0] GRP_UART  = 3'd0;
	localparam logic [2:0] GRP_PWM   = 3'd1;
	localparam logic [2:0] GRP_TIMER = 3'd3;
	localparam logic [2:0] GRP_IRQ   = 3'd7;

	localparam byte_t CTRL_C  = 8'h03;	// Break request byte
	localparam byte_t PWM_MAX = 8'd180;	// Last count, period of 181

	// Status register layout
	localparam int ST_RXVALID  = 0;
	localparam int ST_TXRDY    = 1;
	localparam int ST_FRAMEERR = 2;
	localparam int ST_OVERRUN  = 3;
	localparam int ST_CTRLC    = 4;
	localparam int ST_DIRTY    = 5;
	localparam int ST_PWMIRQ   = 6;

	// IRQ enable mask layout
	localparam int IE_RXVALID = 0;
	localparam int IE_TXRDY   = 1;
	localparam int IE_PWM     = 2;
	localparam int IE_STEP    = 3;	// User mode, single step
	localparam int IE_CTRLC   = 4;

endpackage

/* src/uartTx.sv */
//////////////////////////////////////////////////
// UART transmitter, 8N1
// Baud divider, 9-bit shift register, bit counter
//////////////////////////////////////////////////

module uartTx #(
	parameter int divider = 16	// Clock cycles per bit
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             wr,	// Load byte, start frame
	input  periphPkg::byte_t d,
	output logic             txd,
	output logic             txRdy
);
	localparam int divW = (divider > 1) ? $clog2(divider) : 1;
	localparam logic [divW-1:0] divLast = divW'(divider - 1);

	logic [divW-1:0] txDiv;		// Baud divider
	logic            txTick;	// Bit boundary
	logic [8:0]      txSh;		// Data plus start bit
	logic [3:0]      txBitCnt;	// Bits left, zero when idle
	logic            txBusy;

	assign txTick = (txDiv == divLast);

	// Divider restarts on every write so the start bit is full length
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			txDiv <= '0;
		end else if (wr || txTick) begin
			txDiv <= '0;
		end else begin
			txDiv <= txDiv + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			txSh <= 9'h1ff;			// Line idles high
		end else if (wr) begin
			txSh <= {d, 1'b0};		// Start bit at LSB
		end else if (txTick) begin
			txSh <= {1'b1, txSh[8:1]};	// Ones fill in, last one is the stop bit
		end
	end

	// Start, eight data, stop
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			txBitCnt <= '0;
		end else if (wr) begin
			txBitCnt <= 4'd10;
		end else if (txBusy && txTick) begin
			txBitCnt <= txBitCnt - 1'b1;
		end
	end

	assign txBusy = |txBitCnt;
	assign txRdy  = ~txBusy;
	assign txd    = txSh[0];

	// The top must stall the bus master instead of writing a busy transmitter
	assert property (@(posedge clk) disable iff (reset) wr |-> !txBusy)
		else $error("uartTx: write while frame in progress");

endmodule

/* src/uartRx.sv */
//////////////////////////////////////////////////
// UART receiver, 8N1
// Synchronizer, edge-locked divider, shift
// register, buffer and valid/overrun flags
//////////////////////////////////////////////////

module uartRx #(
	parameter int divider = 16	// Clock cycles per bit
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             rxd,
	input  logic             rd,	// Data read, clears flags
	output periphPkg::byte_t q,
	output logic             rxValid,
	output logic             overrun,
	output logic             frameErr
);
	localparam int divW = (divider > 1) ? $clog2(divider) : 1;
	localparam logic [divW-1:0] divLast  = divW'(divider - 1);
	localparam logic [divW-1:0] sampleAt = divW'(divider / 2 - 1);	// Mid-bit

	logic [1:0]      rxSync;	// Two flops on the async line
	logic            rxEdge;
	logic [divW-1:0] rxDiv;
	logic            rxSample;
	logic [9:0]      rxSh;		// Start marker walks down to bit 0
	logic            rxDone;
	logic [8:0]      rxBuf;		// Stop bit and data
	logic [1:0]      rxFlags;	// 01 valid, 11 overrun

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxSync <= 2'b11;
		end else begin
			rxSync <= {rxSync[0], rxd};
		end
	end

	assign rxEdge = rxSync[1] ^ rxSync[0];

	// Any line transition realigns the bit clock
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxDiv <= '0;
		end else if (rxEdge || (rxDiv == divLast)) begin
			rxDiv <= '0;
		end else begin
			rxDiv <= rxDiv + 1'b1;
		end
	end

	assign rxSample = (rxDiv == sampleAt);
	assign rxDone   = ~rxSh[0];	// Start bit reached the end

	////////////////////////////////////////////////////
	// Shift register and receive buffer
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxSh <= 10'h3ff;
		end else if (rxDone) begin
			rxSh <= 10'h3ff;	// Rearm for the next frame
		end else if (rxSample) begin
			rxSh <= {rxSync[1], rxSh[9:1]};
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxBuf <= 9'h100;	// Stop bit high, no framing error
		end else if (rxDone) begin
			rxBuf <= rxSh[9:1];
		end
	end

	// New frame wins over a read in the same cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxFlags <= 2'b00;
		end else if (rxDone) begin
			rxFlags <= {rxFlags[0], 1'b1};
		end else if (rd) begin
			rxFlags <= 2'b00;
		end
	end

	assign q        = rxBuf[7:0];
	assign frameErr = ~rxBuf[8];	// Low stop bit
	assign rxValid  = rxFlags[0];
	assign overrun  = rxFlags[1];

endmodule

/* src/pwmGen.sv */
//////////////////////////////////////////////////
// PWM generator with fixed period
// Duty buffer reloaded at wrap, end-of-period IRQ
//////////////////////////////////////////////////

module pwmGen (
	input  logic             clk,
	input  logic             reset,
	input  logic             wr,	// Duty write, clears IRQ
	input  periphPkg::byte_t d,
	output logic             pwmOut,
	output logic             pwmIrq
);
	import periphPkg::*;

	byte_t pwmCnt;		// Period counter, 0..PWM_MAX
	byte_t dutyNext;	// Written value
	byte_t dutyAct;		// Value for the running period
	logic  cntZero;
	logic  cntLast;

	assign cntZero = (pwmCnt == '0);
	assign cntLast = (pwmCnt == PWM_MAX);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pwmCnt   <= '0;
			dutyNext <= '0;
			dutyAct  <= '0;	// Output stays low until a duty is loaded
		end else begin
			pwmCnt <= cntLast ? '0 : pwmCnt + 1'b1;
			if (wr)
				dutyNext <= d;
			if (cntLast)
				dutyAct <= dutyNext;	// Reload only at wrap, no glitches
		end
	end

	// High from count 1 through count duty, so duty cycles per period
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pwmOut <= 1'b0;
			pwmIrq <= 1'b0;
		end else begin
			if (pwmCnt == dutyAct)
				pwmOut <= 1'b0;
			else if (cntZero)
				pwmOut <= 1'b1;
			pwmIrq <= cntZero ? 1'b1 : (wr ? 1'b0 : pwmIrq);
		end
	end

	assert property (@(posedge clk) disable iff (reset) pwmCnt <= PWM_MAX)
		else $error("pwmGen: counter past end of period");

endmodule

/* src/irqCtrl.sv */
//////////////////////////////////////////////////
// Interrupt controller
// Enable mask, four vectors, pending groups and
// fixed priority vector select
//////////////////////////////////////////////////

module irqCtrl (
	input  logic                clk,
	input  logic                reset,
	input  logic                enWr,	// Enable mask write
	input  logic                vecWr,	// Full word vector write
	input  logic [1:0]          vecIdx,
	input  periphPkg::word_t    wdata,
	input  logic                rxValid,
	input  logic                txRdy,
	input  logic                pwmIrq,
	input  logic                ctrlC,
	input  logic                userMode,
	input  logic                trap,	// ECALL / EBREAK from the core
	output periphPkg::irqEn_t   irqEn,
	output logic                irq,
	output periphPkg::vecAddr_t ivector
);
	import periphPkg::*;

	vecAddr_t   vecTab [4];	// 0 trap, 1 step/ctrl-C, 2 UART, 3 PWM
	logic [2:0] pend;	// Pending groups
	logic [1:0] vecN;	// Selected vector

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			irqEn <= '0;
		end else if (enWr) begin
			irqEn <= wdata[4:0];
		end
	end

	always_ff @(posedge clk) begin
		if (vecWr)
			vecTab[vecIdx] <= wdata[31:2];	// Word aligned, low bits dropped
	end

	////////////////////////////////////////////////////
	// Pending groups and priority
	assign pend[2] = (irqEn[IE_STEP] & userMode) | (irqEn[IE_CTRLC] & ctrlC);
	assign pend[1] = irqEn[IE_PWM] & pwmIrq;
	assign pend[0] = (irqEn[IE_TXRDY] & txRdy) | (irqEn[IE_RXVALID] & rxValid);

	always_comb begin
		if (trap)
			vecN = 2'd0;	// Highest
		else if (pend[2])
			vecN = 2'd1;	// Single step or control-C
		else if (pend[0])
			vecN = 2'd2;	// UART
		else
			vecN = 2'd3;	// PWM
	end

	assign ivector = vecTab[vecN];
	assign irq     = (|pend) | trap;

	// A trap always interrupts, whatever the mask, and takes vector 0
	assert property (@(posedge clk) disable iff (reset)
		trap |-> (irq && (ivector == vecTab[0])))
		else $error("irqCtrl: trap not routed to vector 0");

endmodule

/* src/periphTop.sv */
//////////////////////////////////////////////////
// Peripheral block top: address decode, stall,
// read mux, timer, debug flags and instances
//////////////////////////////////////////////////

module periphTop #(
	parameter int divider = 16	// Clock cycles per UART bit
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                ioSel,	// Access qualifier
	input  periphPkg::regAddr_t addr,
	input  periphPkg::word_t    wdata,
	input  periphPkg::strb_t    wstrb,	// Zero means read
	output periphPkg::word_t    rdata,
	output logic                stall,
	input  logic                rxd,
	input  logic [3:0]          gpIn,
	input  logic                trap,
	input  logic                userMode,
	output logic                txd,
	output logic                pwmOut,
	output logic                irq,
	output periphPkg::vecAddr_t ivector
);
	import periphPkg::*;

	logic [2:0] grp;	// Address bits 7..5
	logic       anyStrb, isRead, uartData;
	logic       txWrReq, rxRdReq;
	logic       go, wrGo;
	logic       txWr, rxRd, statWr, pwmWr, enWr, vecWr;
	logic       txRdy, rxValid, overrun, frameErr, pwmIrq, ctrlC;
	byte_t      rxq;
	irqEn_t     irqEn;
	word_t      timer;
	logic       dirty;	// Byte sent since last status write
	word_t      statusWord;

	////////////////////////////////////////////////////
	// Decode and stall
	assign grp      = addr[5:3];
	assign anyStrb  = |wstrb;
	assign isRead   = ~anyStrb;
	assign uartData = ioSel && (grp == GRP_UART) && !addr[0];
	assign txWrReq  = uartData && anyStrb;
	assign rxRdReq  = uartData && isRead;

	// Blocking RX read and TX write
	assign stall = (rxRdReq && !rxValid) || (txWrReq && !txRdy);
	assign go    = ioSel && !stall;
	assign wrGo  = go && anyStrb;

	assign txWr   = txWrReq && !stall;
	assign rxRd   = rxRdReq && !stall;	// Clears valid and overrun
	assign statWr = wrGo && (grp == GRP_UART) && addr[0];
	assign pwmWr  = wrGo && (grp == GRP_PWM);
	assign enWr   = wrGo && (grp == GRP_IRQ) && !addr[2];
	assign vecWr  = go && (grp == GRP_IRQ) && addr[2] && (wstrb == 4'hf);	// Word only

	////////////////////////////////////////////////////
	// Timer and debug flags
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			timer <= '0;
			dirty <= 1'b0;
		end else begin
			timer <= timer + 1'b1;
			dirty <= txWr ? 1'b1 : (statWr ? 1'b0 : dirty);
		end
	end

	assign ctrlC = rxValid && (rxq == CTRL_C);

	// Read mux
	always_comb begin
		statusWord              = '0;
		statusWord[ST_RXVALID]  = rxValid;
		statusWord[ST_TXRDY]    = txRdy;
		statusWord[ST_FRAMEERR] = frameErr;
		statusWord[ST_OVERRUN]  = overrun;
		statusWord[ST_CTRLC]    = ctrlC;
		statusWord[ST_DIRTY]    = dirty;
		statusWord[ST_PWMIRQ]   = pwmIrq;
		case (grp)
			GRP_UART:  rdata = addr[0] ? statusWord : {24'h0, rxq};
			GRP_PWM:   rdata = {28'h0, gpIn};
			GRP_TIMER: rdata = timer;
			GRP_IRQ:   rdata = {27'h0, irqEn};
			default:   rdata = '0;
		endcase
	end

	////////////////////////////////////////////////////
	// Peripherals
	uartTx #(.divider(divider)) uTx (
		.clk(clk), .reset(reset), .wr(txWr), .d(wdata[7:0]),
		.txd(txd), .txRdy(txRdy)
	);

	uartRx #(.divider(divider)) uRx (
		.clk(clk), .reset(reset), .rxd(rxd), .rd(rxRd), .q(rxq),
		.rxValid(rxValid), .overrun(overrun), .frameErr(frameErr)
	);

	pwmGen uPwm (
		.clk(clk), .reset(reset), .wr(pwmWr), .d(wdata[7:0]),
		.pwmOut(pwmOut), .pwmIrq(pwmIrq)
	);

	irqCtrl uIrq (
		.clk(clk), .reset(reset), .enWr(enWr), .vecWr(vecWr), .vecIdx(addr[1:0]),
		.wdata(wdata), .rxValid(rxValid), .txRdy(txRdy), .pwmIrq(pwmIrq),
		.ctrlC(ctrlC), .userMode(userMode), .trap(trap),
		.irqEn(irqEn), .irq(irq), .ivector(ivector)
	);

endmodule

/* dv/periphTb.sv */
//////////////////////////////////////////////////
// Peripheral block testbench: clock, reset, bus
// tasks, serial driver, stimulus table and checks
//////////////////////////////////////////////////

module periphTb;
	import periphPkg::*;

	localparam int DIV = 16;	// UART bit time in cycles
	localparam int unsigned SEED = 32'hc5a593f7;

	// Watchdog budget, frames include one idle bit
	localparam int FRAMES = 10;
	localparam int PWM_PERIODS = 20;
	localparam int LIMIT = FRAMES * 11 * DIV + PWM_PERIODS * (PWM_MAX + 1) + 2000;

	// Register addresses, word address bits 7..2
	localparam regAddr_t A_DATA  = {GRP_UART, 3'b000};
	localparam regAddr_t A_STAT  = {GRP_UART, 3'b001};
	localparam regAddr_t A_PWM   = {GRP_PWM, 3'b000};
	localparam regAddr_t A_TIMER = {GRP_TIMER, 3'b000};
	localparam regAddr_t A_IEN   = {GRP_IRQ, 3'b000};

	// Table operations
	localparam logic [3:0] OP_WR = 4'd0;	// Bus write
	localparam logic [3:0] OP_RD = 4'd1;	// Read, masked compare
	localparam logic [3:0] OP_RDB = 4'd2;	// Read that must stall first
	localparam logic [3:0] OP_LOOP = 4'd3;	// Select rxd source
	localparam logic [3:0] OP_SEND = 4'd4;	// Serial frame, d[8] is the stop bit
	localparam logic [3:0] OP_PWM = 4'd5;	// Duty measurement
	localparam logic [3:0] OP_IRQ = 4'd6;	// d[0] trap, d[1] userMode
	localparam logic [3:0] OP_PINS = 4'd7;	// {irq, stall, pwmOut}
	localparam logic [3:0] OP_TIMER = 4'd8;	// Two reads d cycles apart
	localparam logic [3:0] OP_GPIN = 4'd9;
	localparam logic [3:0] OP_WAITPWM = 4'd10;
	localparam logic [3:0] OP_END = 4'd11;	// Close the current test

	typedef struct packed {
		logic [3:0] op;
		regAddr_t   a;
		word_t      d;
		word_t      exp;
		word_t      mask;
	} row_t;

	logic     clk, reset;
	logic     ioSel, trap, userMode;
	regAddr_t addr;
	word_t    wdata, rdata;
	strb_t    wstrb;
	logic     stall, rxd, txd, pwmOut, irq;
	logic [3:0] gpIn;
	vecAddr_t ivector;

	logic loopback;	// rxd from txd
	logic drvRxd;	// Serial driver line

	row_t  stim [$];
	int    cycleCnt, checkCnt, errCount, testErr, testIdx, testsFailed;
	string names [6] = '{"reset state", "uart loopback", "uart rx flags",
		"pwm duty", "irq priority", "timer and gpio"};

	assign rxd = loopback ? txd : drvRxd;

	periphTop #(.divider(DIV)) dut_i (
		.clk(clk), .reset(reset), .ioSel(ioSel), .addr(addr), .wdata(wdata),
		.wstrb(wstrb), .rdata(rdata), .stall(stall), .rxd(rxd), .gpIn(gpIn),
		.trap(trap), .userMode(userMode), .txd(txd), .pwmOut(pwmOut),
		.irq(irq), .ivector(ivector)
	);

	always #20 clk = ~clk;	// Period 40

	// Watchdog
	always @(posedge clk) begin
		cycleCnt++;
		if (cycleCnt >= LIMIT) begin
			$display("timeout: run still busy after %0d cycles", LIMIT);
			$display("sim failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	task automatic checkValue(input string name, input word_t got, input word_t want);
		checkCnt++;
		assert (got == want)
		else begin
			$display("Fail %s got 0x%0h exp 0x%0h", name, got, want);
			errCount++;
			testErr++;
		end
	endtask

	function automatic word_t vecWord(input int n);
		return 32'h1000 * (n + 1);	// Vector n handler address
	endfunction

	function automatic word_t irqExp(input int n);
		word_t v;
		v = vecWord(n);
		return {2'b10, v[31:2]};	// Bit 31 irq high, then ivector
	endfunction

	// One access, held while stalled, released on the next falling edge
	task automatic busAccess(input regAddr_t a, input word_t wd, input strb_t st,
		output word_t rd, output logic stalled);
		@(negedge clk);
		ioSel = 1'b1;
		addr  = a;
		wdata = wd;
		wstrb = st;
		stalled = 1'b0;
		#10;	// Mid low phase, combinational outputs settled
		while (stall) begin
			stalled = 1'b1;
			@(negedge clk);
			#10;
		end
		rd = rdata;
		@(negedge clk);	// Access taken at the rising edge between
		ioSel = 1'b0;
		wstrb = '0;
	endtask

	task automatic waitStatusBit(input int bitIdx);
		word_t rd;
		logic  s;
		logic  done;
		done = 1'b0;
		while (!done) begin
			busAccess(A_STAT, '0, '0, rd, s);
			done = rd[bitIdx];
		end
	endtask

	// Start, 8 data LSB first, chosen stop bit, one idle bit
	task automatic sendFrame(input word_t f);
		@(negedge clk);
		drvRxd = 1'b0;
		repeat (DIV) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			drvRxd = f[i];
			repeat (DIV) @(negedge clk);
		end
		drvRxd = f[8];
		repeat (DIV) @(negedge clk);
		drvRxd = 1'b1;
		repeat (DIV) @(negedge clk);
	endtask

	// Reload made sure by two end-of-period flags, then one full period counted
	task automatic measurePwm(input word_t duty, output int highs);
		word_t rd;
		logic  s;
		busAccess(A_PWM, duty, 4'hf, rd, s);
		waitStatusBit(ST_PWMIRQ);
		busAccess(A_PWM, duty, 4'hf, rd, s);	// Clears the flag
		busAccess(A_STAT, '0, '0, rd, s);
		checkValue("pwmIrq", {31'h0, rd[ST_PWMIRQ]}, '0);
		waitStatusBit(ST_PWMIRQ);
		highs = 0;
		repeat (PWM_MAX + 1) begin
			@(negedge clk);
			if (pwmOut)
				highs++;
		end
	endtask

	task automatic addRow(input logic [3:0] op, input regAddr_t a, input word_t d,
		input word_t exp, input word_t mask);
		row_t r;
		r.op   = op;
		r.a    = a;
		r.d    = d;
		r.exp  = exp;
		r.mask = mask;
		stim.push_back(r);
	endtask

	//////////////////////////////////////////////////
	// Stimulus table
	task automatic buildTable();
		word_t b, b1, b2, b3;
		// Reset state
		addRow(OP_PINS, A_DATA, 0, 0, 0);
		addRow(OP_RD, A_STAT, 0, 32'h02, 32'h3f);	// Only txRdy
		addRow(OP_RD, A_IEN, 0, 0, 32'h1f);
		addRow(OP_END, A_DATA, 0, 0, 0);
		// Loopback with blocking reads
		addRow(OP_LOOP, A_DATA, 1, 0, 0);
		for (int i = 0; i < 4; i++) begin
			b = $urandom & 32'hff;
			addRow(OP_WR, A_DATA, b, 0, 0);
			addRow(OP_RDB, A_DATA, 0, b, 32'hff);
		end
		addRow(OP_RD, A_STAT, 0, 32'h20, 32'h21);	// Dirty set, valid clear
		addRow(OP_WR, A_STAT, 0, 0, 0);
		addRow(OP_RD, A_STAT, 0, 0, 32'h20);
		addRow(OP_END, A_DATA, 0, 0, 0);
		// Overrun, framing error, control-C
		b1 = $urandom & 32'hff;
		b2 = $urandom & 32'hff;
		b3 = $urandom & 32'hff;
		addRow(OP_LOOP, A_DATA, 0, 0, 0);
		addRow(OP_SEND, A_DATA, 32'h100 | b1, 0, 0);
		addRow(OP_SEND, A_DATA, 32'h100 | b2, 0, 0);
		addRow(OP_RD, A_STAT, 0, 32'h0b, 32'h0f);	// Overrun, txRdy, valid
		addRow(OP_RD, A_DATA, 0, b2, 32'hff);
		addRow(OP_RD, A_STAT, 0, 32'h02, 32'h0f);
		addRow(OP_SEND, A_DATA, b3, 0, 0);	// Low stop bit
		addRow(OP_RD, A_STAT, 0, 32'h07, 32'h0f);
		addRow(OP_RD, A_DATA, 0, b3, 32'hff);
		addRow(OP_SEND, A_DATA, 32'h100 | CTRL_C, 0, 0);
		addRow(OP_RD, A_STAT, 0, 32'h13, 32'h1f);
		addRow(OP_RD, A_DATA, 0, CTRL_C, 32'hff);
		addRow(OP_RD, A_STAT, 0, 32'h02, 32'h1f);
		addRow(OP_END, A_DATA, 0, 0, 0);
		// PWM duty, exp is the high count per period
		addRow(OP_PWM, A_PWM, 0, 0, 0);
		addRow(OP_PWM, A_PWM, 1, 1, 0);
		addRow(OP_PWM, A_PWM, 90, 90, 0);
		addRow(OP_PWM, A_PWM, PWM_MAX, PWM_MAX, 0);
		addRow(OP_END, A_DATA, 0, 0, 0);
		// Interrupt priority
		for (int i = 0; i < 4; i++)
			addRow(OP_WR, {GRP_IRQ, 1'b1, i[1:0]}, vecWord(i), 0, 0);
		addRow(OP_WR, A_IEN, 0, 0, 0);
		addRow(OP_WAITPWM, A_STAT, 0, 0, 0);
		addRow(OP_SEND, A_DATA, 32'h155, 0, 0);	// rxValid and pwmIrq both up
		addRow(OP_IRQ, A_DATA, 0, 0, 0);
		addRow(OP_IRQ, A_DATA, 2, 0, 0);
		addRow(OP_IRQ, A_DATA, 1, irqExp(0), 0);	// Trap ignores the mask
		addRow(OP_WR, A_IEN, 32'h1d, 0, 0);	// All but TX ready
		addRow(OP_RD, A_IEN, 0, 32'h1d, 32'h1f);
		addRow(OP_IRQ, A_DATA, 0, irqExp(2), 0);
		addRow(OP_IRQ, A_DATA, 2, irqExp(1), 0);
		addRow(OP_IRQ, A_DATA, 3, irqExp(0), 0);
		addRow(OP_RD, A_DATA, 0, 32'h55, 32'hff);
		addRow(OP_IRQ, A_DATA, 0, irqExp(3), 0);	// PWM alone
		addRow(OP_IRQ, A_DATA, 2, irqExp(1), 0);
		addRow(OP_WR, A_PWM, 0, 0, 0);
		addRow(OP_WAITPWM, A_STAT, 0, 0, 0);
		addRow(OP_WR, A_PWM, 0, 0, 0);	// Fresh period, flag low
		addRow(OP_IRQ, A_DATA, 0, 0, 0);
		addRow(OP_IRQ, A_DATA, 1, irqExp(0), 0);
		addRow(OP_SEND, A_DATA, 32'h100 | CTRL_C, 0, 0);
		addRow(OP_IRQ, A_DATA, 0, irqExp(1), 0);	// Control-C over UART
		addRow(OP_RD, A_DATA, 0, CTRL_C, 32'hff);
		addRow(OP_WR, A_IEN, 0, 0, 0);
		addRow(OP_IRQ, A_DATA, 0, 0, 0);
		addRow(OP_END, A_DATA, 0, 0, 0);
		// Timer and general inputs
		addRow(OP_TIMER, A_TIMER, 37, 37, 0);
		addRow(OP_TIMER, A_TIMER, 100, 100, 0);
		addRow(OP_GPIN, A_DATA, 32'ha, 0, 0);
		addRow(OP_RD, A_PWM, 0, 32'ha, 32'hffffffff);
		addRow(OP_GPIN, A_DATA, 32'h5, 0, 0);
		addRow(OP_RD, A_PWM, 0, 32'h5, 32'hffffffff);
		addRow(OP_END, A_DATA, 0, 0, 0);
	endtask

	task automatic runRow(input row_t r);
		word_t rd, t1, t2;
		logic  s;
		int    highs;
		case (r.op)
			OP_WR: busAccess(r.a, r.d, 4'hf, rd, s);
			OP_RD: begin
				busAccess(r.a, '0, '0, rd, s);
				checkValue("rdata", rd & r.mask, r.exp);
			end
			OP_RDB: begin
				busAccess(r.a, '0, '0, rd, s);
				checkCnt++;
				assert (s)
				else begin
					$display("data read at addr 0x%0h returned without a stall", r.a);
					errCount++;
					testErr++;
				end
				checkValue("rdata", rd & r.mask, r.exp);
			end
			OP_LOOP: begin
				@(negedge clk);
				loopback = r.d[0];
			end
			OP_SEND: begin
				sendFrame(r.d);
				waitStatusBit(ST_RXVALID);
			end
			OP_PWM: begin
				measurePwm(r.d, highs);
				checkValue("pwmOut high cycles", highs, r.exp);
			end
			OP_IRQ: begin
				@(negedge clk);
				trap     = r.d[0];
				userMode = r.d[1];
				#10;
				checkValue("irq", {31'h0, irq}, {31'h0, r.exp[31]});
				if (r.exp[31])
					checkValue("ivector", {2'b00, ivector}, {2'b00, r.exp[29:0]});
			end
			OP_PINS: begin
				@(negedge clk);
				#10;
				checkValue("irq/stall/pwmOut", {29'h0, irq, stall, pwmOut}, r.exp);
			end
			OP_TIMER: begin
				@(negedge clk);
				ioSel = 1'b1;	// Reads have no side effect, held
				addr  = r.a;
				wstrb = '0;
				#10;
				t1 = rdata;
				repeat (r.d) @(negedge clk);
				#10;
				t2 = rdata;
				checkValue("timer delta", t2 - t1, r.exp);
				@(negedge clk);
				ioSel = 1'b0;
			end
			OP_GPIN: begin
				@(negedge clk);
				gpIn = r.d[3:0];
			end
			OP_WAITPWM: waitStatusBit(ST_PWMIRQ);
			OP_END: begin
				$display("test %0d %s: %s, %0d errors", testIdx + 1, names[testIdx],
					(testErr == 0) ? "ok" : "FAILED", testErr);
				if (testErr != 0)
					testsFailed++;
				testErr = 0;
				testIdx++;
			end
			default: $display("unknown table operation %0d", r.op);
		endcase
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	initial begin
		clk = 1'b0;
		reset = 1'b1;
		ioSel = 1'b0;
		addr = '0;
		wdata = '0;
		wstrb = '0;
		gpIn = '0;
		trap = 1'b0;
		userMode = 1'b0;
		loopback = 1'b0;
		drvRxd = 1'b1;	// Idle line
		cycleCnt = 0;
		checkCnt = 0;
		errCount = 0;
		testErr = 0;
		testIdx = 0;
		testsFailed = 0;
		void'($urandom(SEED));
		buildTable();
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		foreach (stim[i])
			runRow(stim[i]);
		$display("%0d tests, %0d failed, %0d checks, %0d errors", testIdx, testsFailed,
			checkCnt, errCount);
		if (errCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* larvaPeriph.f */
src/periphPkg.sv
src/uartTx.sv
src/uartRx.sv
src/pwmGen.sv
src/irqCtrl.sv
src/periphTop.sv
dv/periphTb.sv

/* run.sh */
#!/bin/sh
# Build and run the peripheral block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f larvaPeriph.f \
	--top-module periphTb \
	-Mdir obj_dir -o periphSim

out=$(./obj_dir/periphSim)
echo "$out"

# Result decided by the testbench's closing message
echo "$out" | grep -q "sim passed"
